// File: files.f
hdl/snowball_pkg.sv
hdl/snowball_ram.sv
hdl/snowball_tlb.sv
hdl/snowball_cache.sv
hdl/snowball_mem_port.sv
hdl/snowball_top.sv
sim/snowball_checker.sv
sim/snowball_mem_model.sv
sim/snowball_tb.sv

// File: Bender.yml
package:
  name: snowball

sources:
  - hdl/snowball_pkg.sv
  - hdl/snowball_ram.sv
  - hdl/snowball_tlb.sv
  - hdl/snowball_cache.sv
  - hdl/snowball_mem_port.sv
  - hdl/snowball_top.sv
  - target: simulation
    files:
      - sim/snowball_checker.sv
      - sim/snowball_mem_model.sv
      - sim/snowball_tb.sv

// File: sim/snowball_tb.sv
`timescale 1ns/1ps
`default_nettype none

module snowball_tb;

  import snowball_pkg::*;

  localparam int    TIMEOUT_CYCLES = 50;
  localparam word_t FILL_MASK      = 32'h5a5a0000;  // Unwritten memory pattern
  localparam word_t LFSR_SEED      = 32'hab5de8fc;
  localparam word_t LFSR_TAPS      = 32'h80200003;

  logic  CPU_CLK;
  logic  RST;
  word_t cache_addr;
  word_t cache_wdata;
  logic  cache_we;
  logic  cache_enable;
  logic  cache_force_miss;
  logic  cache_inhibit;
  logic  vmem_act;
  logic  tlb_we;
  word_t cache_rdata;
  logic  cache_busy;
  logic  mmu_fault;
  logic  mem_req;
  logic  mem_we;
  word_t mem_addr;
  word_t mem_wdata;
  logic  mem_ack;
  word_t mem_rdata;
  logic  dma_read;
  logic  dma_write;
  logic  dma_read_ack;
  logic  dma_write_ack;
  word_t dma_rdata;
  int    mem_reads;
  int    mem_writes;
  int    dma_reads;
  int    dma_writes;
  word_t last_addr;
  word_t last_wdata;
  word_t lfsr;
  int    errors;
  int    tests_run;
  int    tests_failed;

  // Same index 8'h77, different tags
  word_t addr_list_c [3] = '{32'h0000_3377, 32'h0001_3377, 32'h0000_3377};

  always #50 CPU_CLK = ~CPU_CLK;  // 100 ns period

  snowball_top u_dut
  (
    .CPU_CLK          (CPU_CLK),
    .RST              (RST),
    .cache_addr       (cache_addr),
    .cache_wdata      (cache_wdata),
    .cache_we         (cache_we),
    .cache_enable     (cache_enable),
    .cache_force_miss (cache_force_miss),
    .cache_inhibit    (cache_inhibit),
    .vmem_act         (vmem_act),
    .tlb_we           (tlb_we),
    .cache_rdata      (cache_rdata),
    .cache_busy       (cache_busy),
    .mmu_fault        (mmu_fault),
    .mem_req          (mem_req),
    .mem_we           (mem_we),
    .mem_addr         (mem_addr),
    .mem_wdata        (mem_wdata),
    .mem_ack          (mem_ack),
    .mem_rdata        (mem_rdata),
    .dma_read         (dma_read),
    .dma_write        (dma_write),
    .dma_read_ack     (dma_read_ack),
    .dma_write_ack    (dma_write_ack),
    .dma_rdata        (dma_rdata)
  );

  snowball_mem_model u_mem_model
  (
    .CPU_CLK       (CPU_CLK),
    .mem_req       (mem_req),
    .mem_we        (mem_we),
    .mem_addr      (mem_addr),
    .mem_wdata     (mem_wdata),
    .mem_ack       (mem_ack),
    .mem_rdata     (mem_rdata),
    .dma_read      (dma_read),
    .dma_write     (dma_write),
    .dma_read_ack  (dma_read_ack),
    .dma_write_ack (dma_write_ack),
    .dma_rdata     (dma_rdata),
    .mem_reads     (mem_reads),
    .mem_writes    (mem_writes),
    .dma_reads     (dma_reads),
    .dma_writes    (dma_writes),
    .last_addr     (last_addr),
    .last_wdata    (last_wdata)
  );

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  function automatic word_t next_random(input int nbits);
    word_t value;
    int    i;
    value = '0;
    for (i = 0; i < nbits; i++)
    begin
      value = {value[30:0], lfsr[0]};
      lfsr  = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
    end
    return value;
  endfunction

  function automatic int total_requests();
    return mem_reads + mem_writes + dma_reads + dma_writes;
  endfunction

  task automatic check_value(input string what, input word_t got, input word_t expected);
    if (got !== expected)
    begin
      $display("FAILED at time %0t: %s, got %h, expected %h", $time, what, got, expected);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before)
      $display("Test %s: ok", name);
    else
    begin
      tests_failed++;
      $display("Test %s: %0d errors", name, errors - errors_before);
    end
  endtask

  // One CPU access or TLB load, returns once busy has fallen
  task automatic run_access
  (
    input  word_t addr,
    input  word_t wdata,
    input  logic  we,
    input  logic  force_miss,
    input  logic  vmem,
    input  logic  tlb_load,
    output word_t rdata,
    output int    busy_cycles,
    output logic  fault_seen
  );
    @(negedge CPU_CLK);
    cache_addr       = addr;
    cache_wdata      = wdata;
    cache_we         = we;
    cache_force_miss = force_miss;
    vmem_act         = vmem;
    cache_enable     = !tlb_load;
    tlb_we           = tlb_load;
    @(negedge CPU_CLK);  // Accepted on the edge in between
    cache_enable = 1'b0;
    tlb_we       = 1'b0;
    busy_cycles  = 0;
    fault_seen   = 1'b0;
    if (!cache_busy)
    begin
      $display("Request for address %h at time %0t was not accepted", addr, $time);
      errors++;
    end
    while (cache_busy && (busy_cycles < TIMEOUT_CYCLES))
    begin
      busy_cycles++;
      @(negedge CPU_CLK);
      fault_seen = fault_seen | mmu_fault;  // Pulses with busy falling
    end
    if (cache_busy)
    begin
      $display("Timeout at time %0t, cache_busy never fell for address %h", $time, addr);
      errors++;
    end
    rdata = cache_rdata;
  endtask

  // --------------------------------------------------------------------------
  // Directed tests
  // --------------------------------------------------------------------------
  task automatic test_miss_then_hit();
    word_t addr;
    word_t got;
    int    n0;
    int    cycles;
    int    err0;
    logic  flt;
    err0 = errors;
    addr = 32'h0000_1234;
    n0   = total_requests();
    run_access(addr, '0, 1'b0, 1'b0, 1'b0, 1'b0, got, cycles, flt);
    check_value("miss read data", got, addr ^ FILL_MASK);
    check_value("miss request count", total_requests() - n0, 1);
    n0 = total_requests();
    run_access(addr, '0, 1'b0, 1'b0, 1'b0, 1'b0, got, cycles, flt);
    check_value("hit read data", got, addr ^ FILL_MASK);
    check_value("hit request count", total_requests() - n0, 0);
    check_value("hit busy cycles", cycles, 2);
    finish_test("miss_then_hit", err0);
  endtask

  task automatic test_write_through();
    word_t addr;
    word_t data;
    word_t got;
    int    n0;
    int    cycles;
    int    err0;
    logic  flt;
    err0 = errors;
    addr = 32'h0000_2256;
    data = 32'hcafe_0101;
    n0   = mem_writes;
    run_access(addr, data, 1'b1, 1'b0, 1'b0, 1'b0, got, cycles, flt);
    check_value("memory write count", mem_writes - n0, 1);
    check_value("memory write address", last_addr, addr);
    check_value("memory write data", last_wdata, data);
    n0 = total_requests();
    run_access(addr, '0, 1'b0, 1'b0, 1'b0, 1'b0, got, cycles, flt);
    check_value("read after write data", got, data);
    check_value("read after write requests", total_requests() - n0, 0);
    check_value("read after write busy cycles", cycles, 2);
    finish_test("write_through", err0);
  endtask

  task automatic test_force_inhibit_conflict();
    word_t addr;
    word_t got;
    int    n0;
    int    cycles;
    int    err0;
    logic  flt;
    err0 = errors;
    addr = 32'h0000_1234;  // Cached by the first test
    n0   = total_requests();
    run_access(addr, '0, 1'b0, 1'b1, 1'b0, 1'b0, got, cycles, flt);
    check_value("force miss data", got, addr ^ FILL_MASK);
    check_value("force miss requests", total_requests() - n0, 1);
    n0 = total_requests();
    @(negedge CPU_CLK);
    cache_addr    = addr;
    cache_we      = 1'b0;
    vmem_act      = 1'b0;
    cache_enable  = 1'b1;
    cache_inhibit = 1'b1;
    repeat (3)
    begin
      @(negedge CPU_CLK);
      check_value("busy with inhibit", cache_busy, 1'b0);
    end
    cache_enable  = 1'b0;
    cache_inhibit = 1'b0;
    check_value("inhibit requests", total_requests() - n0, 0);
    foreach (addr_list_c[i])
    begin
      n0 = total_requests();
      run_access(addr_list_c[i], '0, 1'b0, 1'b0, 1'b0, 1'b0, got, cycles, flt);
      check_value("conflict read data", got, addr_list_c[i] ^ FILL_MASK);
      check_value("conflict requests", total_requests() - n0, 1);
    end
    finish_test("force_inhibit_conflict", err0);
  endtask

  task automatic test_translation();
    word_t paddr;
    word_t got;
    int    n0;
    int    cycles;
    int    err0;
    logic  flt;
    err0 = errors;
    // TLB entry 8'h45, virtual tag 16'h1234, physical tag 16'h0077
    run_access(32'h1234_4500, 32'h1234_0077, 1'b0, 1'b0, 1'b0, 1'b1, got, cycles, flt);
    check_value("TLB load busy cycles", cycles, 1);
    paddr = 32'h0077_4510;
    n0    = mem_reads;
    run_access(32'h1234_4510, '0, 1'b0, 1'b0, 1'b1, 1'b0, got, cycles, flt);
    check_value("translated address", last_addr, paddr);
    check_value("translated read data", got, paddr ^ FILL_MASK);
    check_value("translated requests", mem_reads - n0, 1);
    check_value("translated fault", flt, 1'b0);
    finish_test("translation", err0);
  endtask

  task automatic test_fault();
    word_t got;
    int    n0;
    int    cycles;
    int    err0;
    logic  flt;
    err0 = errors;
    n0   = total_requests();
    run_access(32'h4321_4520, '0, 1'b0, 1'b0, 1'b1, 1'b0, got, cycles, flt);
    check_value("fault pulse", flt, 1'b1);
    check_value("fault busy cycles", cycles, 2);
    check_value("fault requests", total_requests() - n0, 0);
    finish_test("fault", err0);
  endtask

  task automatic test_dma_regions();
    word_t addr;
    word_t rnd;
    word_t got;
    int    n0;
    int    i;
    int    cycles;
    int    err0;
    logic  flt;
    err0 = errors;
    addr = '0;
    for (i = 0; i < 4; i++)
    begin
      rnd  = next_random(30);
      addr = {2'b11, rnd[29:0]};
      n0   = dma_reads;
      run_access(addr, '0, 1'b0, 1'b0, 1'b0, 1'b0, got, cycles, flt);
      check_value("DMA read data", got, ~addr);
      check_value("DMA read requests", dma_reads - n0, 1);
    end
    n0 = dma_reads;  // Uncached, so a repeat goes out again
    run_access(addr, '0, 1'b0, 1'b0, 1'b0, 1'b0, got, cycles, flt);
    check_value("DMA repeat data", got, ~addr);
    check_value("DMA repeat requests", dma_reads - n0, 1);
    n0 = dma_writes;
    run_access(32'hc000_0040, 32'h1357_9bdf, 1'b1, 1'b0, 1'b0, 1'b0, got, cycles, flt);
    check_value("DMA write count", dma_writes - n0, 1);
    check_value("DMA write address", last_addr, 32'hc000_0040);
    check_value("DMA write data", last_wdata, 32'h1357_9bdf);
    n0 = total_requests();
    run_access(32'h4000_0010, '0, 1'b0, 1'b0, 1'b0, 1'b0, got, cycles, flt);
    check_value("unmapped read data", got, '0);
    check_value("unmapped requests", total_requests() - n0, 0);
    finish_test("dma_regions", err0);
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------
  initial
  begin
    CPU_CLK          = 1'b0;
    RST              = 1'b1;
    cache_addr       = '0;
    cache_wdata      = '0;
    cache_we         = 1'b0;
    cache_enable     = 1'b0;
    cache_force_miss = 1'b0;
    cache_inhibit    = 1'b0;
    vmem_act         = 1'b0;
    tlb_we           = 1'b0;
    lfsr             = LFSR_SEED;
    errors           = 0;
    tests_run        = 0;
    tests_failed     = 0;
    repeat (3) @(posedge CPU_CLK);
    @(negedge CPU_CLK);
    RST = 1'b0;
    check_value("busy after reset", cache_busy, 1'b0);
    test_miss_then_hit();
    test_write_through();
    test_force_inhibit_conflict();
    test_translation();
    test_fault();
    test_dma_regions();
    $display("Tests run %0d, tests failed %0d, checks failed %0d, assertion failures %0d",
             tests_run, tests_failed, errors, u_dut.u_checker.failures);
    if ((errors == 0) && (u_dut.u_checker.failures == 0))
    begin
      $display("Simulation passed");
    end
    else
    begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/snowball_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module snowball_mem_model
(
  input  wire                 CPU_CLK,
  input  wire                 mem_req,
  input  wire                 mem_we,
  input  wire snowball_pkg::word_t mem_addr,
  input  wire snowball_pkg::word_t mem_wdata,
  output logic                mem_ack,
  output snowball_pkg::word_t mem_rdata,
  input  wire                 dma_read,
  input  wire                 dma_write,
  output logic                dma_read_ack,
  output logic                dma_write_ack,
  output snowball_pkg::word_t dma_rdata,
  output int                  mem_reads,
  output int                  mem_writes,
  output int                  dma_reads,
  output int                  dma_writes,
  output snowball_pkg::word_t last_addr,
  output snowball_pkg::word_t last_wdata
);

  import snowball_pkg::*;

  localparam word_t FILL_MASK = 32'h5a5a0000;
  localparam word_t LFSR_SEED = 32'hab5de8fc;
  localparam word_t LFSR_TAPS = 32'h80200003;
  localparam int    DEPTH     = 64;

  word_t lfsr;
  word_t store_addr [DEPTH];
  word_t store_data [DEPTH];
  int    stored;

  function automatic word_t next_random(input int nbits);
    word_t value;
    int    i;
    value = '0;
    for (i = 0; i < nbits; i++)
    begin
      value = {value[30:0], lfsr[0]};  // One step per bit
      lfsr  = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
    end
    return value;
  endfunction

  function automatic word_t read_word(input word_t addr);
    word_t value;
    int    i;
    value = addr ^ FILL_MASK;  // Unwritten words
    for (i = 0; i < stored; i++)
    begin
      if (store_addr[i] == addr)
        value = store_data[i];  // Latest write wins
    end
    return value;
  endfunction

  // --------------------------------------------------------------------------
  // Responders, acknowledge after 1 to 4 cycles
  // --------------------------------------------------------------------------
  task automatic serve_mem();
    int delay;
    delay = 1 + next_random(2);
    repeat (delay - 1) @(negedge CPU_CLK);
    last_addr  = mem_addr;
    last_wdata = mem_wdata;
    if (mem_we)
    begin
      mem_writes++;
      if (stored < DEPTH)
      begin
        store_addr[stored] = mem_addr;
        store_data[stored] = mem_wdata;
        stored++;
      end
    end
    else
    begin
      mem_reads++;
      mem_rdata = read_word(mem_addr);
    end
    mem_ack = 1'b1;
    @(negedge CPU_CLK);
    mem_ack = 1'b0;  // Request was dropped on the rising edge
  endtask

  task automatic serve_dma();
    int delay;
    delay = 1 + next_random(2);
    repeat (delay - 1) @(negedge CPU_CLK);
    last_addr  = mem_addr;  // DMA shares the memory address bus
    last_wdata = mem_wdata;
    if (dma_write)
    begin
      dma_writes++;
      dma_write_ack = 1'b1;
    end
    else
    begin
      dma_reads++;
      dma_rdata    = ~mem_addr;
      dma_read_ack = 1'b1;
    end
    @(negedge CPU_CLK);
    dma_read_ack  = 1'b0;
    dma_write_ack = 1'b0;
  endtask

  initial
  begin
    lfsr          = LFSR_SEED;
    stored        = 0;
    mem_ack       = 1'b0;
    mem_rdata     = '0;
    dma_read_ack  = 1'b0;
    dma_write_ack = 1'b0;
    dma_rdata     = '0;
    mem_reads     = 0;
    mem_writes    = 0;
    dma_reads     = 0;
    dma_writes    = 0;
    last_addr     = '0;
    last_wdata    = '0;
    forever
    begin
      @(negedge CPU_CLK);
      if (mem_req === 1'b1)
        serve_mem();
      else if ((dma_read === 1'b1) || (dma_write === 1'b1))
        serve_dma();
    end
  end

endmodule

`default_nettype wire

// File: sim/snowball_checker.sv
`timescale 1ns/1ps
`default_nettype none

module snowball_checker
(
  input wire CPU_CLK,
  input wire RST,
  input wire cache_busy,
  input wire mmu_fault,
  input wire vmem_act,
  input wire mem_req,
  input wire mem_ack,
  input wire dma_read,
  input wire dma_read_ack,
  input wire dma_write,
  input wire dma_write_ack
);

  int failures = 0;  // Failed assertions so far

  // --------------------------------------------------------------------------
  // Protocol properties
  // --------------------------------------------------------------------------
  busy_after_reset: assert property (@(posedge CPU_CLK) RST |=> !cache_busy)
    else begin $error("cache_busy high after reset"); failures++; end

  one_request_line: assert property (@(posedge CPU_CLK) disable iff (RST)
    $onehot0({mem_req, dma_read, dma_write}))
    else begin $error("More than one request line high"); failures++; end

  mem_req_holds: assert property (@(posedge CPU_CLK) disable iff (RST)
    mem_req && !mem_ack |=> mem_req)
    else begin $error("mem_req dropped before mem_ack"); failures++; end

  dma_read_holds: assert property (@(posedge CPU_CLK) disable iff (RST)
    dma_read && !dma_read_ack |=> dma_read)
    else begin $error("dma_read dropped before its ack"); failures++; end

  dma_write_holds: assert property (@(posedge CPU_CLK) disable iff (RST)
    dma_write && !dma_write_ack |=> dma_write)
    else begin $error("dma_write dropped before its ack"); failures++; end

  // A fault is seen three edges after the accepting edge
  fault_needs_vmem: assert property (@(posedge CPU_CLK) disable iff (RST)
    mmu_fault |-> $past(vmem_act, 3))
    else begin $error("mmu_fault without vmem_act"); failures++; end

endmodule

bind snowball_top snowball_checker u_checker
(
  .CPU_CLK       (CPU_CLK),
  .RST           (RST),
  .cache_busy    (cache_busy),
  .mmu_fault     (mmu_fault),
  .vmem_act      (vmem_act),
  .mem_req       (mem_req),
  .mem_ack       (mem_ack),
  .dma_read      (dma_read),
  .dma_read_ack  (dma_read_ack),
  .dma_write     (dma_write),
  .dma_write_ack (dma_write_ack)
);

`default_nettype wire

// File: hdl/snowball_top.sv
`timescale 1ns/1ps
`default_nettype none

module snowball_top
(
  input  wire                 CPU_CLK,
  input  wire                 RST,
  // CPU side
  input  wire snowball_pkg::word_t cache_addr,
  input  wire snowball_pkg::word_t cache_wdata,
  input  wire                 cache_we,
  input  wire                 cache_enable,
  input  wire                 cache_force_miss,
  input  wire                 cache_inhibit,
  input  wire                 vmem_act,
  input  wire                 tlb_we,
  output snowball_pkg::word_t cache_rdata,
  output logic                cache_busy,
  output logic                mmu_fault,
  // Main memory
  output logic                mem_req,
  output logic                mem_we,
  output snowball_pkg::word_t mem_addr,
  output snowball_pkg::word_t mem_wdata,
  input  wire                 mem_ack,
  input  wire snowball_pkg::word_t mem_rdata,
  // DMA space
  output logic                dma_read,
  output logic                dma_write,
  input  wire                 dma_read_ack,
  input  wire                 dma_write_ack,
  input  wire snowball_pkg::word_t dma_rdata
);

  import snowball_pkg::*;

  logic  tlb_lookup;
  logic  tlb_load;
  word_t paddr;
  logic  fault;
  logic  port_req;
  word_t port_addr;
  logic  port_we;
  word_t port_wdata;
  logic  port_done;
  word_t port_rdata;

  snowball_tlb u_tlb
  (
    .CPU_CLK   (CPU_CLK),
    .RST       (RST),
    .lookup    (tlb_lookup),
    .load      (tlb_load),
    .vaddr     (cache_addr),
    .load_data (cache_wdata),  // Virtual tag high, physical tag low
    .vmem_act  (vmem_act),
    .paddr     (paddr),
    .fault     (fault)
  );

  snowball_cache u_cache
  (
    .CPU_CLK          (CPU_CLK),
    .RST              (RST),
    .cache_addr       (cache_addr),
    .cache_wdata      (cache_wdata),
    .cache_we         (cache_we),
    .cache_enable     (cache_enable),
    .cache_force_miss (cache_force_miss),
    .cache_inhibit    (cache_inhibit),
    .tlb_we           (tlb_we),
    .cache_rdata      (cache_rdata),
    .cache_busy       (cache_busy),
    .mmu_fault        (mmu_fault),
    .tlb_lookup       (tlb_lookup),
    .tlb_load         (tlb_load),
    .paddr            (paddr),
    .fault            (fault),
    .port_req         (port_req),
    .port_addr        (port_addr),
    .port_we          (port_we),
    .port_wdata       (port_wdata),
    .port_done        (port_done),
    .port_rdata       (port_rdata)
  );

  snowball_mem_port u_mem_port
  (
    .CPU_CLK       (CPU_CLK),
    .RST           (RST),
    .port_req      (port_req),
    .port_addr     (port_addr),
    .port_we       (port_we),
    .port_wdata    (port_wdata),
    .port_done     (port_done),
    .port_rdata    (port_rdata),
    .mem_req       (mem_req),
    .mem_we        (mem_we),
    .mem_addr      (mem_addr),
    .mem_wdata     (mem_wdata),
    .mem_ack       (mem_ack),
    .mem_rdata     (mem_rdata),
    .dma_read      (dma_read),
    .dma_write     (dma_write),
    .dma_read_ack  (dma_read_ack),
    .dma_write_ack (dma_write_ack),
    .dma_rdata     (dma_rdata)
  );

endmodule

`default_nettype wire

// File: hdl/snowball_mem_port.sv
`timescale 1ns/1ps
`default_nettype none

module snowball_mem_port
(
  input  wire                 CPU_CLK,
  input  wire                 RST,
  // Cache side
  input  wire                 port_req,
  input  wire snowball_pkg::word_t port_addr,
  input  wire                 port_we,
  input  wire snowball_pkg::word_t port_wdata,
  output logic                port_done,
  output snowball_pkg::word_t port_rdata,
  // Main memory
  output logic                mem_req,
  output logic                mem_we,
  output snowball_pkg::word_t mem_addr,
  output snowball_pkg::word_t mem_wdata,
  input  wire                 mem_ack,
  input  wire snowball_pkg::word_t mem_rdata,
  // DMA space
  output logic                dma_read,
  output logic                dma_write,
  input  wire                 dma_read_ack,
  input  wire                 dma_write_ack,
  input  wire snowball_pkg::word_t dma_rdata
);

  import snowball_pkg::*;

  region_t region;

  assign region = port_addr[31:30];

  // --------------------------------------------------------------------------
  // Request lines and completion
  // --------------------------------------------------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (RST)
    begin
      mem_req   <= 1'b0;
      mem_we    <= 1'b0;
      dma_read  <= 1'b0;
      dma_write <= 1'b0;
      port_done <= 1'b0;
    end
    else
    begin
      port_done <= 1'b0;
      if (port_req)
      begin
        case (region)
          REGION_MEM:
          begin
            mem_req <= 1'b1;
            mem_we  <= port_we;
          end
          REGION_DMA:
          begin
            dma_read  <= !port_we;
            dma_write <= port_we;
          end
          REGION_NONE_01, REGION_NONE_10:
            port_done <= 1'b1;  // Nothing out there, finish at once
        endcase
      end
      if (mem_req && mem_ack)
      begin
        mem_req   <= 1'b0;  // Drop on the edge that samples the ack
        mem_we    <= 1'b0;
        port_done <= 1'b1;
      end
      if (dma_read && dma_read_ack)
      begin
        dma_read  <= 1'b0;
        port_done <= 1'b1;
      end
      if (dma_write && dma_write_ack)
      begin
        dma_write <= 1'b0;
        port_done <= 1'b1;
      end
    end
  end

  // Address and data are shared by main memory and DMA
  always_ff @(posedge CPU_CLK)
  begin
    if (port_req)
    begin
      mem_addr  <= port_addr;
      mem_wdata <= port_wdata;
      if ((region == REGION_NONE_01) || (region == REGION_NONE_10))
        port_rdata <= '0;
    end
    if (mem_req && mem_ack && !mem_we)
      port_rdata <= mem_rdata;
    if (dma_read && dma_read_ack)
      port_rdata <= dma_rdata;
  end

endmodule

`default_nettype wire

// File: hdl/snowball_cache.sv
`timescale 1ns/1ps
`default_nettype none

module snowball_cache
(
  input  wire                 CPU_CLK,
  input  wire                 RST,
  // CPU side
  input  wire snowball_pkg::word_t cache_addr,
  input  wire snowball_pkg::word_t cache_wdata,
  input  wire                 cache_we,
  input  wire                 cache_enable,
  input  wire                 cache_force_miss,
  input  wire                 cache_inhibit,
  input  wire                 tlb_we,
  output snowball_pkg::word_t cache_rdata,
  output logic                cache_busy,
  output logic                mmu_fault,
  // TLB
  output logic                tlb_lookup,
  output logic                tlb_load,
  input  wire snowball_pkg::word_t paddr,
  input  wire                 fault,
  // Memory port
  output logic                port_req,
  output snowball_pkg::word_t port_addr,
  output logic                port_we,
  output snowball_pkg::word_t port_wdata,
  input  wire                 port_done,
  input  wire snowball_pkg::word_t port_rdata
);

  import snowball_pkg::*;

  cache_state_t state;
  logic         accept;
  logic         force_q;
  logic         fault_q;
  logic         hit;
  logic         fill;
  logic [255:0] valid;
  idx_t         rd_idx;
  idx_t         lookup_idx;
  idx_t         fill_idx;
  ctag_t        tag_rd;
  word_t        data_rd;
  word_t        fill_data;
  region_t      lookup_region;
  region_t      port_region;

  // --------------------------------------------------------------------------
  // Acceptance and lookup decode
  // --------------------------------------------------------------------------
  assign accept = (state == IDLE) &&
                  ((cache_enable && !cache_inhibit) || tlb_we);
  assign tlb_lookup = accept;
  assign tlb_load   = accept && tlb_we;  // TLB load wins over a cache access

  assign rd_idx        = cache_addr[7:0];
  assign lookup_idx    = paddr[7:0];
  assign lookup_region = paddr[31:30];
  assign port_region   = port_addr[31:30];
  assign fill_idx      = port_addr[7:0];

  // Writes never hit, they always go out to memory
  assign hit = !port_we && !force_q && valid[lookup_idx] &&
               (tag_rd == paddr[31:8]) && (lookup_region == REGION_MEM);

  // Read miss fill or write update, main memory only
  assign fill      = (state == WAIT_PORT) && port_done && (port_region == REGION_MEM);
  assign fill_data = port_we ? port_wdata : port_rdata;

  snowball_ram #(.WIDTH($bits(word_t)), .ADDR_BITS($bits(idx_t))) u_data_ram
  (
    .CPU_CLK (CPU_CLK),
    .re      (accept),
    .raddr   (rd_idx),
    .rdata   (data_rd),
    .we      (fill),
    .waddr   (fill_idx),
    .wdata   (fill_data)
  );

  snowball_ram #(.WIDTH($bits(ctag_t)), .ADDR_BITS($bits(idx_t))) u_tag_ram
  (
    .CPU_CLK (CPU_CLK),
    .re      (accept),
    .raddr   (rd_idx),
    .rdata   (tag_rd),
    .we      (fill),
    .waddr   (fill_idx),
    .wdata   (port_addr[31:8])
  );

  // --------------------------------------------------------------------------
  // Control FSM
  // --------------------------------------------------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (RST)
    begin
      state      <= IDLE;
      cache_busy <= 1'b0;
      mmu_fault  <= 1'b0;
      port_req   <= 1'b0;
      fault_q    <= 1'b0;
      valid      <= '0;
    end
    else
    begin
      port_req  <= 1'b0;  // Single cycle pulses
      mmu_fault <= 1'b0;
      case (state)
        IDLE:
        begin
          if (accept)
          begin
            cache_busy <= 1'b1;
            fault_q    <= 1'b0;
            state      <= tlb_we ? DONE : LOOKUP;
          end
        end
        LOOKUP:
        begin
          if (fault)
          begin
            fault_q <= 1'b1;  // No port access on a fault
            state   <= DONE;
          end
          else if (hit)
            state <= DONE;
          else
          begin
            port_req <= 1'b1;
            state    <= WAIT_PORT;
          end
        end
        WAIT_PORT:
        begin
          if (fill)
            valid[fill_idx] <= 1'b1;
          if (port_done)
            state <= DONE;
        end
        DONE:
        begin
          cache_busy <= 1'b0;
          mmu_fault  <= fault_q;  // Pulses with busy falling
          state      <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Request payload and returned data
  always_ff @(posedge CPU_CLK)
  begin
    if (accept)
    begin
      port_we    <= cache_we;
      port_wdata <= cache_wdata;
      force_q    <= cache_force_miss;
    end
    if (state == LOOKUP)
    begin
      port_addr <= paddr;  // Held through WAIT_PORT for the fill
      if (hit)
        cache_rdata <= data_rd;
    end
    if ((state == WAIT_PORT) && port_done && !port_we)
      cache_rdata <= port_rdata;
  end

endmodule

`default_nettype wire

// File: hdl/snowball_tlb.sv
`timescale 1ns/1ps
`default_nettype none

module snowball_tlb
(
  input  wire                 CPU_CLK,
  input  wire                 RST,
  input  wire                 lookup,
  input  wire                 load,
  input  wire snowball_pkg::word_t vaddr,
  input  wire snowball_pkg::word_t load_data,
  input  wire                 vmem_act,
  output snowball_pkg::word_t paddr,
  output logic                fault
);

  import snowball_pkg::*;

  idx_t  tlb_idx;
  vtag_t vtag_rd;
  ptag_t ptag_rd;
  word_t vaddr_q;
  logic  vmem_q;

  assign tlb_idx = vaddr[15:8];  // Same index for lookup and load

  snowball_ram #(.WIDTH($bits(vtag_t)), .ADDR_BITS($bits(idx_t))) u_vtag_ram
  (
    .CPU_CLK (CPU_CLK),
    .re      (lookup),
    .raddr   (tlb_idx),
    .rdata   (vtag_rd),
    .we      (load),
    .waddr   (tlb_idx),
    .wdata   (load_data[31:16])
  );

  snowball_ram #(.WIDTH($bits(ptag_t)), .ADDR_BITS($bits(idx_t))) u_ptag_ram
  (
    .CPU_CLK (CPU_CLK),
    .re      (lookup),
    .raddr   (tlb_idx),
    .rdata   (ptag_rd),
    .we      (load),
    .waddr   (tlb_idx),
    .wdata   (load_data[15:0])
  );

  always_ff @(posedge CPU_CLK)
  begin
    if (RST)
      vmem_q <= 1'b0;
    else if (lookup)
      vmem_q <= vmem_act;  // Mode is fixed for the whole access
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (lookup)
      vaddr_q <= vaddr;
  end

  // Valid in the cycle after acceptance, when the arrays have been read
  assign paddr = vmem_q ? {ptag_rd, vaddr_q[15:0]} : vaddr_q;
  assign fault = vmem_q && (vtag_rd != vaddr_q[31:16]);

endmodule

`default_nettype wire

// File: hdl/snowball_ram.sv
`timescale 1ns/1ps
`default_nettype none

module snowball_ram
#(
  parameter int WIDTH     = 32,
  parameter int ADDR_BITS = 8
)
(
  input  wire                 CPU_CLK,
  input  wire                 re,
  input  wire [ADDR_BITS-1:0] raddr,
  output logic [WIDTH-1:0]    rdata,
  input  wire                 we,
  input  wire [ADDR_BITS-1:0] waddr,
  input  wire [WIDTH-1:0]     wdata
);

  logic [WIDTH-1:0] mem [2**ADDR_BITS];

  always_ff @(posedge CPU_CLK)
  begin
    if (we)
    begin
      mem[waddr] <= wdata;
    end
    if (re)
    begin
      rdata <= mem[raddr];  // Old data on a same-address collision
    end
  end

endmodule

`default_nettype wire

// File: hdl/snowball_pkg.sv
`default_nettype none

package snowball_pkg;

  // --------------------------------------------------------------------------
  // Vector types
  // --------------------------------------------------------------------------
  typedef logic [31:0] word_t;    // Data word or word address
  typedef logic [7:0]  idx_t;     // Cache index or TLB index
  typedef logic [15:0] vtag_t;    // Virtual page tag, addr[31:16]
  typedef logic [15:0] ptag_t;    // Physical page tag from the TLB
  typedef logic [23:0] ctag_t;    // Cache line tag, paddr[31:8]
  typedef logic [1:0]  region_t;  // Physical addr[31:30]

  // --------------------------------------------------------------------------
  // Physical regions
  // --------------------------------------------------------------------------
  localparam region_t REGION_MEM     = 2'b00;  // Cacheable main memory
  localparam region_t REGION_NONE_01 = 2'b01;  // Unmapped, reads zero
  localparam region_t REGION_NONE_10 = 2'b10;  // Unmapped, reads zero
  localparam region_t REGION_DMA     = 2'b11;  // Uncached DMA space

  // Cache control FSM
  typedef enum logic [1:0]
  {
    IDLE      = 2'd0,
    LOOKUP    = 2'd1,
    WAIT_PORT = 2'd2,
    DONE      = 2'd3
  } cache_state_t;

endpackage

`default_nettype wire
